/* Bender.yml */
package:
  name: st_mem_glue

sources:
  - files:
      - rtl/st_mem_pkg.sv
      - rtl/st_cfg_decode.sv
      - rtl/viking_detect.sv
      - rtl/upload_tracker.sv
      - rtl/sdram_req_mux.sv
      - rtl/st_mem_glue.sv
  - target: test
    files:
      - tests/tb_st_mem_glue.sv

/* filelist.f */
rtl/st_mem_pkg.sv
rtl/st_cfg_decode.sv
rtl/viking_detect.sv
rtl/upload_tracker.sv
rtl/sdram_req_mux.sv
rtl/st_mem_glue.sv
tests/tb_st_mem_glue.sv

/* rtl/sdram_req_mux.sv */
/* picks the sdram request source per bus slot (upload, viking fetch or ram
   cycle), checks ram cycles against the installed window, remaps rom-2 */

`timescale 1ns/1ps

module sdram_req_mux import st_mem_pkg::*; (
	input  logic              clk_32,
	input  logic              xsint,
	input  bus_slot_e         bus_slot_i,
	input  ram_size_e         ram_size_i,
	input  logic              steroids_i,
	input  logic              viking_enable_i,
	input  logic              viking_active_i,
	input  logic              ras_n_i,
	input  logic [ADDR_W:1]   ram_addr_i,
	input  logic              ram_we_n_i,
	input  logic              ram_uds_i,
	input  logic              ram_lds_i,
	input  logic [DATA_W-1:0] ram_din_i,
	input  logic              dio_download_i,
	input  logic [ADDR_W:1]   dio_addr_i,
	input  logic [DATA_W-1:0] dio_data_i,
	input  logic              upload_wr_i,
	input  logic              viking_read_i,
	input  logic [ADDR_W:1]   viking_addr_i,
	input  logic              rom2_n_i,
	input  logic [ADDR_W:1]   cpu_addr_i,
	input  logic              tos192k_i,
	output logic [ADDR_W:1]   sdram_addr_o,
	output logic              sdram_req_o,
	output logic              sdram_we_o,
	output logic [1:0]        sdram_ds_o,       // {uds, lds}
	output logic [DATA_W-1:0] sdram_din_o,
	output logic [ADDR_W:1]   rom_addr_o
);

	logic ras_n_q;
	logic ram_req;
	logic ram_en;
	logic upload_sel;
	logic viking_sel;

	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint)
			ras_n_q <= 1'b1;  // no edge straight out of reset
		else
			ras_n_q <= ras_n_i;
	end

	// falling ras edge, address 0 is the reset vector read from rom
	assign ram_req = ras_n_q && !ras_n_i && (|ram_addr_i);

	always_comb begin
		case (ram_size_i)
			RAM_512K: ram_en = (ram_addr_i[23:19] == 5'b00000);
			RAM_1M:   ram_en = (ram_addr_i[23:20] == 4'b0000);
			RAM_2M:   ram_en = (ram_addr_i[23:21] == 3'b000);
			RAM_4M:   ram_en = (ram_addr_i[23:22] == 2'b00);
			RAM_8M:   ram_en = !ram_addr_i[23];
			RAM_14M:  ram_en = (ram_addr_i[23:21] != 3'b111);  // up to $dfffff
			default:  ram_en = 1'b0;
		endcase
		// viking video ram, 256k at $c0 or 512k at $e8
		if (viking_enable_i && !steroids_i && (ram_addr_i[23:18] == VIKING_BASE_ST))
			ram_en = 1'b1;
		if (viking_enable_i && steroids_i && (ram_addr_i[23:19] == VIKING_BASE_HI[5:1]))
			ram_en = 1'b1;
	end

	assign upload_sel = (bus_slot_i == SLOT_CPU) && dio_download_i;
	assign viking_sel = (bus_slot_i == SLOT_VIDEO) && viking_active_i && viking_read_i;

	always_comb begin
		if (upload_sel) begin
			sdram_addr_o = dio_addr_i;
			sdram_req_o  = upload_wr_i;   // cpu is held off during upload
			sdram_we_o   = 1'b1;
			sdram_ds_o   = 2'b11;         // full words
		end else if (viking_sel) begin
			sdram_addr_o = viking_addr_i;  // takes over the shifter slot
			sdram_req_o  = 1'b1;
			sdram_we_o   = !ram_we_n_i;
			sdram_ds_o   = {ram_uds_i, ram_lds_i};
		end else begin
			sdram_addr_o = ram_addr_i;
			sdram_req_o  = ram_req && ram_en;
			sdram_we_o   = !ram_we_n_i;
			sdram_ds_o   = {ram_uds_i, ram_lds_i};
		end
	end

	assign sdram_din_o = dio_download_i ? dio_data_i : ram_din_i;

	// rom-2 lives where the tos image was uploaded
	always_comb begin
		if (rom2_n_i)
			rom_addr_o = cpu_addr_i;
		else if (tos192k_i)
			rom_addr_o = {4'hF, 2'b11, cpu_addr_i[17:1]};  // $fc0000
		else
			rom_addr_o = {4'hE, 2'b00, cpu_addr_i[17:1]};  // $e00000
	end

endmodule

/* rtl/st_cfg_decode.sv */
/* latches the io controller's system control word and decodes ram size,
   steroids mode and viking enable, one clock behind the input */

`timescale 1ns/1ps

module st_cfg_decode import st_mem_pkg::*; (
	input  logic              clk_32,
	input  logic              xsint,
	input  logic [CTRL_W-1:0] sys_ctrl_i,
	output ram_size_e         ram_size_o,
	output logic              steroids_o,
	output logic              viking_enable_o
);

	logic [2:0] size_code;
	ram_size_e  size_dec;
	logic       steroids_dec;
	logic       viking_dec;

	assign size_code = sys_ctrl_i[CTRL_RAM_LSB +: 3];

	// codes 6 and 7 are not a valid st config, fall back to 512k
	assign size_dec = (size_code > 3'd5) ? RAM_512K : ram_size_e'(size_code);

	// ste and mega ste both set means a ste on steroids
	assign steroids_dec = sys_ctrl_i[CTRL_STE_BIT] & sys_ctrl_i[CTRL_MSTE_BIT];

	// viking video ram sits at $c00000 so 14M excludes it,
	// steroids moves it to $e80000 where it always fits
	assign viking_dec = (sys_ctrl_i[CTRL_VIKING_BIT] && (size_dec <= RAM_8M)) ||
	                    steroids_dec;

	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			ram_size_o      <= RAM_512K;  // config latch reads zero
			steroids_o      <= 1'b0;
			viking_enable_o <= 1'b0;
		end else begin
			ram_size_o      <= size_dec;
			steroids_o      <= steroids_dec;
			viking_enable_o <= viking_dec;
		end
	end

endmodule

/* rtl/st_mem_glue.sv */
/* memory side glue between the st bus controller and an sdram port,
   connects config decode, viking detect, upload tracking and the request mux */

`timescale 1ns/1ps

module st_mem_glue import st_mem_pkg::*; (
	input  logic              clk_32,
	input  logic              xsint,
	input  logic [CTRL_W-1:0] sys_ctrl_i,
	input  logic              clk8_en_i,
	input  bus_slot_e         bus_slot_i,
	input  logic              as_n_i,
	input  logic [ADDR_W:1]   cpu_addr_i,
	input  logic              ras_n_i,
	input  logic [ADDR_W:1]   ram_addr_i,
	input  logic              ram_we_n_i,
	input  logic              ram_uds_i,
	input  logic              ram_lds_i,
	input  logic [DATA_W-1:0] ram_din_i,
	input  logic              dio_download_i,
	input  logic              dio_strobe_i,
	input  logic [ADDR_W:1]   dio_addr_i,
	input  logic [DATA_W-1:0] dio_data_i,
	input  logic              viking_read_i,
	input  logic [ADDR_W:1]   viking_addr_i,
	input  logic              rom2_n_i,
	output logic [ADDR_W:1]   sdram_addr_o,
	output logic              sdram_req_o,
	output logic              sdram_we_o,
	output logic [1:0]        sdram_ds_o,
	output logic [DATA_W-1:0] sdram_din_o,
	output logic [ADDR_W:1]   rom_addr_o,
	output logic              viking_active_o
);

	ram_size_e ram_size;
	logic      steroids;
	logic      viking_enable;
	logic      upload_wr;     // slot aligned upload write
	logic      tos192k;

	st_cfg_decode cfg_i (
		.clk_32          (clk_32),
		.xsint           (xsint),
		.sys_ctrl_i      (sys_ctrl_i),
		.ram_size_o      (ram_size),
		.steroids_o      (steroids),
		.viking_enable_o (viking_enable)
	);

	viking_detect vik_i (
		.clk_32          (clk_32),
		.xsint           (xsint),
		.clk8_en_i       (clk8_en_i),
		.as_n_i          (as_n_i),
		.cpu_addr_i      (cpu_addr_i),
		.viking_enable_i (viking_enable),
		.steroids_i      (steroids),
		.viking_active_o (viking_active_o)  // also steers the mux
	);

	upload_tracker upl_i (
		.clk_32          (clk_32),
		.xsint           (xsint),
		.clk8_en_i       (clk8_en_i),
		.bus_slot_i      (bus_slot_i),
		.dio_download_i  (dio_download_i),
		.dio_strobe_i    (dio_strobe_i),
		.dio_addr_i      (dio_addr_i),
		.upload_wr_o     (upload_wr),
		.tos192k_o       (tos192k)
	);

	sdram_req_mux mux_i (
		.clk_32          (clk_32),
		.xsint           (xsint),
		.bus_slot_i      (bus_slot_i),
		.ram_size_i      (ram_size),
		.steroids_i      (steroids),
		.viking_enable_i (viking_enable),
		.viking_active_i (viking_active_o),
		.ras_n_i         (ras_n_i),
		.ram_addr_i      (ram_addr_i),
		.ram_we_n_i      (ram_we_n_i),
		.ram_uds_i       (ram_uds_i),
		.ram_lds_i       (ram_lds_i),
		.ram_din_i       (ram_din_i),
		.dio_download_i  (dio_download_i),
		.dio_addr_i      (dio_addr_i),
		.dio_data_i      (dio_data_i),
		.upload_wr_i     (upload_wr),
		.viking_read_i   (viking_read_i),
		.viking_addr_i   (viking_addr_i),
		.rom2_n_i        (rom2_n_i),
		.cpu_addr_i      (cpu_addr_i),
		.tos192k_i       (tos192k),
		.sdram_addr_o    (sdram_addr_o),
		.sdram_req_o     (sdram_req_o),
		.sdram_we_o      (sdram_we_o),
		.sdram_ds_o      (sdram_ds_o),
		.sdram_din_o     (sdram_din_o),
		.rom_addr_o      (rom_addr_o)
	);

endmodule

/* rtl/st_mem_pkg.sv */
/* shared widths, memory map constants and enums for the ST memory glue
   imported by wildcard in every RTL module header and in the testbench */

package st_mem_pkg;

	// bus geometry
	localparam int ADDR_W = 23;        // word address, bits 23:1
	localparam int DATA_W = 16;        // 68000 data bus
	localparam int CTRL_W = 32;        // io controller system control word

	// hits on the viking window before the card takes over video
	localparam logic [7:0] VIKING_HITS = 8'd255;

	// top six address bits (23:18) of the viking video window
	localparam logic [5:0] VIKING_BASE_ST = 6'b110000;  // $c00000, 256k
	localparam logic [5:0] VIKING_BASE_HI = 6'b111010;  // $e80000, steroids

	// upload address prefixes that tell the tos size
	localparam logic [5:0] TOS192_TAG = 6'b111111;  // $fc0000 old 192k tos
	localparam logic [3:0] TOS256_TAG = 4'hE;       // $e00000 ste tos

	// system control word layout
	localparam int CTRL_RAM_LSB    = 1;   // 3 bit ram size code
	localparam int CTRL_STE_BIT    = 23;
	localparam int CTRL_MSTE_BIT   = 24;
	localparam int CTRL_VIKING_BIT = 28;

	// installed st ram
	typedef enum logic [2:0] {
		RAM_512K = 3'd0,
		RAM_1M   = 3'd1,
		RAM_2M   = 3'd2,
		RAM_4M   = 3'd3,
		RAM_8M   = 3'd4,
		RAM_14M  = 3'd5
	} ram_size_e;

	// sdram bus slot as driven by the mcu
	typedef enum logic [1:0] {
		SLOT_PRE   = 2'd0,   // cpu precycle, upload strobe sampled here
		SLOT_CPU   = 2'd1,
		SLOT_VIDEO = 2'd2,   // shifter or viking fetch
		SLOT_IDLE  = 2'd3
	} bus_slot_e;

endpackage

/* rtl/upload_tracker.sv */
/* turns the io controller's toggle strobe into write pulses aligned to the
   cpu slot, and remembers whether the uploaded tos is the 192k variant */

`timescale 1ns/1ps

module upload_tracker import st_mem_pkg::*; (
	input  logic            clk_32,
	input  logic            xsint,
	input  logic            clk8_en_i,
	input  bus_slot_e       bus_slot_i,
	input  logic            dio_download_i,   // upload in progress
	input  logic            dio_strobe_i,     // flips once per word
	input  logic [ADDR_W:1] dio_addr_i,
	output logic            upload_wr_o,
	output logic            tos192k_o
);

	logic strobe_q;    // strobe level at the last sample
	logic sample;

	// fixed sample point, the next clock is the cpu slot
	assign sample = (bus_slot_i == SLOT_PRE) && clk8_en_i;

	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			strobe_q    <= 1'b0;
			upload_wr_o <= 1'b0;
		end else begin
			upload_wr_o <= 1'b0;  // single clock pulse
			if (sample) begin
				strobe_q <= dio_strobe_i;
				if (dio_strobe_i != strobe_q)
					upload_wr_o <= 1'b1;  // new word waiting
			end
		end
	end

	// tos size follows the address range being uploaded to
	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			tos192k_o <= 1'b0;
		end else if (dio_download_i) begin
			if (dio_addr_i[ADDR_W -: 6] == TOS192_TAG)
				tos192k_o <= 1'b1;   // $fc0000
			else if (dio_addr_i[ADDR_W -: 4] == TOS256_TAG)
				tos192k_o <= 1'b0;   // $e00000
		end
	end

endmodule

/* rtl/viking_detect.sv */
/* watches cpu accesses to the viking video window and flags the card active
   once enough hits show the driver is loaded, sticky until reset */

`timescale 1ns/1ps

module viking_detect import st_mem_pkg::*; (
	input  logic            clk_32,
	input  logic            xsint,
	input  logic            clk8_en_i,        // 8 MHz bus enable
	input  logic            as_n_i,
	input  logic [ADDR_W:1] cpu_addr_i,
	input  logic            viking_enable_i,
	input  logic            steroids_i,
	output logic            viking_active_o
);

	logic [7:0] hit_cnt;
	logic [5:0] win_base;
	logic       hit;

	assign win_base = steroids_i ? VIKING_BASE_HI : VIKING_BASE_ST;  // $e8 or $c0

	// one hit per 8 MHz bus cycle with address strobe low
	assign hit = clk8_en_i && !as_n_i && viking_enable_i &&
	             (cpu_addr_i[ADDR_W -: 6] == win_base) &&
	             (hit_cnt < VIKING_HITS);  // saturate

	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			hit_cnt         <= 8'd0;
			viking_active_o <= 1'b0;
		end else begin
			if (hit)
				hit_cnt <= hit_cnt + 8'd1;

			// stray probes of the area never get this far
			if (hit_cnt == VIKING_HITS)
				viking_active_o <= 1'b1;
		end
	end

endmodule

/* tests/st_mem_tests.dat */
# columns: test id, step kind, a, b, c, expected (hex, addresses are byte addresses)
# cfg a=ctrl word | ram a=addr | upload a=addr b=data c=flip | rom a=cpu b=rom2_n | vikhit a=count b=base c=mask | vik a=addr
1 rst    00fc0010 0    0        0
2 cfg    00000000 0    0        0
2 ram    0007fffe 0    0        1
2 ram    00080000 0    0        0
2 cfg    00000002 0    0        0
2 ram    000ffffe 0    0        1
2 ram    00100000 0    0        0
2 cfg    00000004 0    0        0
2 ram    001ffffe 0    0        1
2 ram    00200000 0    0        0
2 cfg    00000006 0    0        0
2 ram    003ffffe 0    0        1
2 ram    00400000 0    0        0
2 cfg    00000008 0    0        0
2 ram    007ffffe 0    0        1
2 ram    00800000 0    0        0
2 cfg    0000000a 0    0        0
2 ram    00dffffe 0    0        1
2 ram    00e00000 0    0        0
3 cfg    10000006 0    0        0
3 ram    00c00000 0    0        1
3 ram    00c3fffe 0    0        1
3 ram    00c40000 0    0        0
3 cfg    00000006 0    0        0
3 ram    00c00000 0    0        0
3 cfg    01800006 0    0        0
3 ram    00e80000 0    0        1
3 ram    00effffe 0    0        1
3 ram    00f00000 0    0        0
3 ram    00c00000 0    0        0
4 upload 00fc0000 1234 1        1
4 upload 00fc0002 5678 0        0
4 rom    00012346 0    0        00fd2346
4 upload 00e00000 abcd 1        1
4 upload 00e00002 0f0f 1        1
4 rom    00012346 0    0        00e12346
4 rom    00012346 1    0        00012346
5 cfg    10000006 0    0        0
5 vik    00c12340 0    0        0
5 vikhit fe       00c00000 0003fffe 0
5 vikhit 1        00c00000 0003fffe 1
5 vik    00c12340 0    0        1
6 rst    00000000 0    0        0
6 cfg    01800006 0    0        0
6 vik    00e92340 0    0        0
6 vikhit fe       00e80000 0003fffe 0
6 vikhit 1        00e80000 0003fffe 1
6 vik    00e92340 0    0        1

/* tests/tb_st_mem_glue.sv */
/* data driven testbench for the st memory glue, steps and expected values
   come from tests/st_mem_tests.dat, run from the project root */

`timescale 1ns/1ps

module tb_st_mem_glue import st_mem_pkg::*; ();

	logic              clk_32;
	logic              xsint;
	logic [CTRL_W-1:0] sys_ctrl;
	logic              clk8_en;
	bus_slot_e         slot;
	logic              as_n;
	logic [ADDR_W:1]   cpu_addr;
	logic              ras_n;
	logic [ADDR_W:1]   ram_addr;
	logic              ram_we_n;
	logic              ram_uds;
	logic              ram_lds;
	logic [DATA_W-1:0] ram_din;
	logic              dio_download;
	logic              strobe_lvl;      // toggles once per uploaded word
	logic [ADDR_W:1]   dio_addr;
	logic [DATA_W-1:0] dio_data;
	logic              viking_read;
	logic [ADDR_W:1]   viking_addr;
	logic              rom2_n;
	logic [ADDR_W:1]   sdram_addr;
	logic              sdram_req;
	logic              sdram_we;
	logic [1:0]        sdram_ds;
	logic [DATA_W-1:0] sdram_din;
	logic [ADDR_W:1]   rom_addr;
	logic              viking_active;

	// one entry per data line
	int          ids[$];
	logic [63:0] kinds[$];
	logic [31:0] arg_a[$];
	logic [31:0] arg_b[$];
	logic [31:0] arg_c[$];
	logic [31:0] arg_e[$];     // expected value

	int          n_steps = 0;
	bit          loaded = 0;
	int          cur_id = 0;
	int          test_errs = 0;
	int          n_errors = 0;
	int          n_checks = 0;
	int          tests_pass = 0;
	int          tests_fail = 0;
	logic [31:0] rng = 32'hc333;

	st_mem_glue dut_i (
		.clk_32 (clk_32), .xsint (xsint), .sys_ctrl_i (sys_ctrl), .clk8_en_i (clk8_en),
		.bus_slot_i (slot), .as_n_i (as_n), .cpu_addr_i (cpu_addr), .ras_n_i (ras_n),
		.ram_addr_i (ram_addr), .ram_we_n_i (ram_we_n), .ram_uds_i (ram_uds),
		.ram_lds_i (ram_lds), .ram_din_i (ram_din), .dio_download_i (dio_download),
		.dio_strobe_i (strobe_lvl), .dio_addr_i (dio_addr), .dio_data_i (dio_data),
		.viking_read_i (viking_read), .viking_addr_i (viking_addr), .rom2_n_i (rom2_n),
		.sdram_addr_o (sdram_addr), .sdram_req_o (sdram_req), .sdram_we_o (sdram_we),
		.sdram_ds_o (sdram_ds), .sdram_din_o (sdram_din), .rom_addr_o (rom_addr),
		.viking_active_o (viking_active)
	);

	initial begin
		clk_32 = 1'b0;
		forever #10 clk_32 = ~clk_32;  // 50 MHz stand-in for the 32 MHz clock
	end

	// classic lcg, only the middle bits are used
	function automatic logic [31:0] next_rand(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic next_cycle();
		@(posedge clk_32);
		#2;                  // inputs change just after the edge
	endtask

	task automatic expect_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
		n_checks++;
		if (act !== exp) begin
			$display("[FAIL] test %0d %s: expected %h, got %h", cur_id, name, exp, act);
			test_errs++;
			n_errors++;
		end
	endtask

	task automatic check_idle(input logic [31:0] a);
		expect_eq("sdram_req_o", 32'h0, sdram_req);
		expect_eq("viking_active_o", 32'h0, viking_active);
		expect_eq("rom_addr_o", a, {rom_addr, 1'b0});  // rom2 not selected
	endtask

	task automatic apply_reset(input logic [31:0] a);
		next_cycle();
		xsint        = 1'b0;
		sys_ctrl     = '0;
		clk8_en      = 1'b0;
		as_n         = 1'b1;
		rom2_n       = 1'b1;
		strobe_lvl   = 1'b0;   // matches the tracker's cleared sample
		dio_download = 1'b0;
		cpu_addr     = a[23:1];
		repeat (4) begin
			#10 check_idle(a);
			next_cycle();
		end
		xsint = 1'b1;
		#10 check_idle(a);
	endtask

	task automatic load_steps();
		int          fd;
		int          code;
		int          id;
		logic [63:0] kind;
		logic [31:0] a, b, c, e;
		logic [8*160-1:0] rest;
		fd = $fopen("tests/st_mem_tests.dat", "r");
		if (fd != 0) begin
			while (!$feof(fd)) begin
				code = $fscanf(fd, "%d %s %h %h %h %h", id, kind, a, b, c, e);
				if (code == 6) begin
					ids.push_back(id);
					kinds.push_back(kind);
					arg_a.push_back(a);
					arg_b.push_back(b);
					arg_c.push_back(c);
					arg_e.push_back(e);
				end else begin
					code = $fgets(rest, fd);  // comment or blank line
				end
			end
			$fclose(fd);
		end
		n_steps = ids.size();
		loaded  = 1'b1;
	endtask

	task automatic run_step(input int i);
		logic [63:0] k;
		logic [31:0] a, b, c, e;
		logic [31:0] hit_addr;
		k = kinds[i];
		a = arg_a[i];
		b = arg_b[i];
		c = arg_c[i];
		e = arg_e[i];
		if (k == "rst") begin
			apply_reset(a);
		end else if (k == "cfg") begin
			next_cycle();
			sys_ctrl = a;
			next_cycle();         // decode lands one clock later
		end else if (k == "ram") begin
			next_cycle();
			rng      = next_rand(rng);
			ras_n    = 1'b0;      // falling edge against the high copy
			ram_addr = a[23:1];
			ram_we_n = rng[9];    // random cycle attributes
			ram_uds  = rng[10];
			ram_lds  = rng[11];
			ram_din  = rng[27:12];
			#10 expect_eq("sdram_req_o", e, sdram_req);
			expect_eq("sdram_addr_o", a, {sdram_addr, 1'b0});
			expect_eq("sdram_we_o", {31'h0, ~ram_we_n}, sdram_we);  // cpu write strobe is low
			expect_eq("sdram_ds_o", {30'h0, ram_uds, ram_lds}, sdram_ds);
			expect_eq("sdram_din_o", {16'h0, ram_din}, sdram_din);  // no upload running
			next_cycle();
			ras_n = 1'b1;
		end else if (k == "upload") begin
			next_cycle();
			dio_download = 1'b1;
			dio_addr     = a[23:1];
			dio_data     = b[15:0];
			slot         = SLOT_PRE;
			clk8_en      = 1'b1;
			strobe_lvl   = strobe_lvl ^ c[0];
			next_cycle();
			slot    = SLOT_CPU;     // write pulse due in this slot
			clk8_en = 1'b0;
			#10 expect_eq("sdram_req_o", e, sdram_req);
			expect_eq("sdram_we_o", 32'h1, sdram_we);
			expect_eq("sdram_ds_o", 32'h3, sdram_ds);
			expect_eq("sdram_addr_o", a, {sdram_addr, 1'b0});
			expect_eq("sdram_din_o", b, sdram_din);
			next_cycle();
			slot         = SLOT_IDLE;
			dio_download = 1'b0;
		end else if (k == "rom") begin
			next_cycle();
			cpu_addr = a[23:1];
			rom2_n   = b[0];
			#10 expect_eq("rom_addr_o", e, {rom_addr, 1'b0});
			next_cycle();
			rom2_n = 1'b1;
		end else if (k == "vikhit") begin
			for (int n = 0; n < a; n++) begin
				next_cycle();
				rng      = next_rand(rng);
				hit_addr = b | ((rng >> 8) & c);  // somewhere in the window
				cpu_addr = hit_addr[23:1];
				clk8_en  = 1'b1;
				as_n     = 1'b0;
			end
			next_cycle();
			clk8_en = 1'b0;
			as_n    = 1'b1;
			next_cycle();         // flag may take two clocks
			#10 expect_eq("viking_active_o", e, viking_active);
		end else if (k == "vik") begin
			next_cycle();
			slot        = SLOT_VIDEO;
			viking_read = 1'b1;
			viking_addr = a[23:1];
			#10 expect_eq("sdram_req_o", e, sdram_req);
			if (e[0])
				expect_eq("sdram_addr_o", a, {sdram_addr, 1'b0});
			next_cycle();
			slot        = SLOT_IDLE;
			viking_read = 1'b0;
		end else begin
			$display("test %0d: unknown step kind %0s in the data file", cur_id, k);
			test_errs++;
			n_errors++;
		end
	endtask

	// run length limit scales with the step count
	initial begin
		wait (loaded);
		#((n_steps + 300) * 20 * 8);
		$display("watchdog: the run timed out before all steps finished");
		$display("Simulation finished: FAIL");
		$finish;
	end

	initial begin
		xsint        = 1'b0;
		sys_ctrl     = '0;
		clk8_en      = 1'b0;
		slot         = SLOT_IDLE;
		as_n         = 1'b1;
		cpu_addr     = '0;
		ras_n        = 1'b1;
		ram_addr     = '0;
		ram_we_n     = 1'b1;
		ram_uds      = 1'b0;
		ram_lds      = 1'b0;
		ram_din      = '0;
		dio_download = 1'b0;
		strobe_lvl   = 1'b0;
		dio_addr     = '0;
		dio_data     = '0;
		viking_read  = 1'b0;
		viking_addr  = '0;
		rom2_n       = 1'b1;
		load_steps();
		if (n_steps == 0)
			$display("no steps could be read from tests/st_mem_tests.dat");
		for (int i = 0; i < n_steps; i++) begin
			cur_id = ids[i];
			run_step(i);
			if (i == n_steps - 1 || ids[i + 1] != ids[i]) begin
				if (test_errs == 0) begin
					$display("test %0d passed", cur_id);
					tests_pass++;
				end else begin
					$display("test %0d failed with %0d errors", cur_id, test_errs);
					tests_fail++;
				end
				test_errs = 0;
			end
		end
		$display("tests passed %0d, failed %0d, checks %0d, errors %0d",
		         tests_pass, tests_fail, n_checks, n_errors);
		if (n_errors == 0 && n_steps > 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule
